// ==== logic/core_mem.sv ====
/* Memory side of one core. Filters shared L2 responses by core ID and joins
   the data cache, store buffer and request arbiter. One instance per core */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_mem #(
	parameter int CORE_ID = 0
) (
	input  logic                     clk,
	input  logic                     reset,
	input  core_mem_pkg::mem_req_t   req_i,
	output core_mem_pkg::mem_rsp_t   rsp_o,
	output logic [`STRAND_COUNT-1:0] rollback_o,
	output logic [`STRAND_COUNT-1:0] resume_o,
	output l2_msg_pkg::l2_req_t      l2req_o,
	output logic                     l2req_valid_o,
	input  logic                     l2req_ready_i,
	input  l2_msg_pkg::l2_rsp_t      l2rsp_i
);
	import l2_msg_pkg::*;

	l2_rsp_t     rsp_mine;
	l2_req_t     dcache_req;
	l2_req_t     stbuf_req;
	l2_req_t     arb_req;
	logic        dcache_valid;
	logic        dcache_ready;
	logic        stbuf_valid;
	logic        stbuf_ready;
	logic [31:0] fwd_data;
	logic [3:0]  fwd_mask;

	// Other cores' responses are dropped here
	always_comb
	begin
		rsp_mine = l2rsp_i;
		rsp_mine.valid = l2rsp_i.valid && l2rsp_i.core == CORE_ID[`CORE_BITS-1:0];
	end

	always_comb
	begin
		l2req_o = arb_req;
		l2req_o.core = CORE_ID[`CORE_BITS-1:0];
	end

	l1_data_cache dcache (
		.clk           (clk),
		.reset         (reset),
		.req_i         (req_i),
		.fwd_data_i    (fwd_data),
		.fwd_mask_i    (fwd_mask),
		.rsp_o         (rsp_o),
		.l2req_o       (dcache_req),
		.l2req_valid_o (dcache_valid),
		.l2req_ready_i (dcache_ready),
		.l2rsp_i       (rsp_mine)
	);

	store_buffer stbuf (
		.clk           (clk),
		.reset         (reset),
		.req_i         (req_i),
		.fwd_data_o    (fwd_data),
		.fwd_mask_o    (fwd_mask),
		.rollback_o    (rollback_o),
		.resume_o      (resume_o),
		.l2req_o       (stbuf_req),
		.l2req_valid_o (stbuf_valid),
		.l2req_ready_i (stbuf_ready),
		.l2rsp_i       (rsp_mine)
	);

	l2req_arbiter arbiter (
		.clk            (clk),
		.reset          (reset),
		.dcache_req_i   (dcache_req),
		.dcache_valid_i (dcache_valid),
		.dcache_ready_o (dcache_ready),
		.stbuf_req_i    (stbuf_req),
		.stbuf_valid_i  (stbuf_valid),
		.stbuf_ready_o  (stbuf_ready),
		.l2req_o        (arb_req),
		.l2req_valid_o  (l2req_valid_o),
		.l2req_ready_i  (l2req_ready_i)
	);

endmodule

// ==== logic/core_mem_pkg.sv ====
/* Pipeline-side load and store types of the core memory unit.
   One request per cycle, no back-pressure */
`include "core_settings.svh"

package core_mem_pkg;

	typedef enum logic {
		MEM_LOAD,
		MEM_STORE
	} mem_op_t;

	typedef struct packed {
		logic                       valid;
		logic [`STRAND_BITS-1:0]    strand;
		mem_op_t                    op;
		logic [`WORD_ADDR_BITS-1:0] addr;	// Word address
		logic [31:0]                data;	// Store data
		logic [3:0]                 mask;	// Store byte enables
	} mem_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`STRAND_BITS-1:0] strand;
		logic [31:0]             data;
	} mem_rsp_t;

endpackage

// ==== logic/core_settings.svh ====
/* Core and cache dimensions shared by the memory-side RTL.
   Include wherever a width or count below is needed */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_COUNT      4       // Cores sharing one L2
`define STRAND_COUNT    4       // Hardware threads per core
`define CACHE_SETS      8       // Direct-mapped lines in the L1 data cache
`define LINE_WORDS      4       // 32-bit words per line
`define LINE_ADDR_BITS  26

// Derived widths
`define CORE_BITS       $clog2(`CORE_COUNT)
`define STRAND_BITS     $clog2(`STRAND_COUNT)
`define SET_BITS        $clog2(`CACHE_SETS)
`define OFFSET_BITS     $clog2(`LINE_WORDS)
`define WORD_ADDR_BITS  (`LINE_ADDR_BITS + `OFFSET_BITS)

`endif

// ==== logic/l1_data_cache.sv ====
/* Direct-mapped write-through L1 data cache. Hits answer in the next cycle,
   misses wait per strand for a line fill. Store acks refresh resident lines */
`timescale 1ns/1ps
`include "core_settings.svh"

module l1_data_cache (
	input  logic                   clk,
	input  logic                   reset,
	input  core_mem_pkg::mem_req_t req_i,
	input  logic [31:0]            fwd_data_i,
	input  logic [3:0]             fwd_mask_i,
	output core_mem_pkg::mem_rsp_t rsp_o,
	output l2_msg_pkg::l2_req_t    l2req_o,
	output logic                   l2req_valid_o,
	input  logic                   l2req_ready_i,
	input  l2_msg_pkg::l2_rsp_t    l2rsp_i
);
	import core_mem_pkg::*;
	import l2_msg_pkg::*;

	localparam int TAG_BITS = `LINE_ADDR_BITS - `SET_BITS;
	localparam int STRANDS = `STRAND_COUNT;

	logic [`CACHE_SETS-1:0]     line_valid_q;
	logic [TAG_BITS-1:0]        tag_q [`CACHE_SETS];
	line_data_t                 line_q [`CACHE_SETS];
	logic [STRANDS-1:0]         wait_q;	// Load outstanding
	logic [STRANDS-1:0]         sent_q;	// Line load handed to the port
	logic [STRANDS-1:0]         done_q;	// Word ready, answer deferred
	logic [`WORD_ADDR_BITS-1:0] wait_addr_q [STRANDS];
	logic [31:0]                wait_data_q [STRANDS];	// Forwarded bytes, then the answer
	logic [3:0]                 wait_mask_q [STRANDS];
	logic [`STRAND_BITS-1:0]    issue_strand_q;
	mem_rsp_t                   rsp_q;

	logic [TAG_BITS-1:0]     req_tag;
	logic [TAG_BITS-1:0]     rsp_tag;
	logic [`SET_BITS-1:0]    req_set;
	logic [`SET_BITS-1:0]    rsp_set;
	logic [`OFFSET_BITS-1:0] req_off;
	logic                    load;
	logic                    hit;
	logic                    miss;
	logic                    fill;
	logic                    ack;
	logic                    port_free;
	logic                    answer_fill;
	logic [STRANDS-1:0]      issue_cand;
	logic [`STRAND_BITS-1:0] issue_strand;
	logic [`STRAND_BITS-1:0] done_strand;
	logic [`STRAND_BITS-1:0] fill_strand;
	logic [31:0]             fill_word;

	function automatic logic [31:0] merge_bytes(input logic [31:0] base,
		input logic [31:0] over, input logic [3:0] mask);
		logic [31:0] result;
		for (int b = 0; b < 4; b++)
			result[b*8 +: 8] = mask[b] ? over[b*8 +: 8] : base[b*8 +: 8];
		return result;
	endfunction

	function automatic logic [`STRAND_BITS-1:0] first_set(input logic [STRANDS-1:0] bits);
		logic [`STRAND_BITS-1:0] idx;
		idx = '0;
		for (int s = STRANDS - 1; s >= 0; s--)
			if (bits[s])
				idx = s[`STRAND_BITS-1:0];
		return idx;
	endfunction

	assign {req_tag, req_set, req_off} = req_i.addr;
	assign {rsp_tag, rsp_set} = l2rsp_i.address;
	assign load = req_i.valid && req_i.op == MEM_LOAD;
	assign hit = line_valid_q[req_set] && tag_q[req_set] == req_tag;
	assign miss = load && !hit;

	assign fill_strand = l2rsp_i.strand;
	assign fill = l2rsp_i.valid && l2rsp_i.unit == UNIT_DCACHE
		&& wait_q[fill_strand] && !done_q[fill_strand];
	assign ack = l2rsp_i.valid && l2rsp_i.unit == UNIT_STBUF && l2rsp_i.op == L2_STORE;
	assign fill_word = merge_bytes(l2rsp_i.data[wait_addr_q[fill_strand][`OFFSET_BITS-1:0]],
		wait_data_q[fill_strand], wait_mask_q[fill_strand]);

	// Hits own the response slot, older deferred answers come next
	assign answer_fill = fill && !(load && hit) && done_q == '0;
	assign done_strand = first_set(done_q);

	assign port_free = !l2req_valid_o || l2req_ready_i;
	always_comb
	begin
		issue_cand = wait_q & ~sent_q;
		if (miss)
			issue_cand[req_i.strand] = 1'b1;	// New miss can go out right away
	end
	assign issue_strand = first_set(issue_cand);

	always_comb
	begin
		l2req_o = '0;
		l2req_o.unit = UNIT_DCACHE;
		l2req_o.strand = issue_strand_q;
		l2req_o.op = L2_LOAD;
		l2req_o.address = wait_addr_q[issue_strand_q][`WORD_ADDR_BITS-1:`OFFSET_BITS];
	end

	assign rsp_o = rsp_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			line_valid_q <= '0;
			wait_q <= '0;
			sent_q <= '0;
			done_q <= '0;
			l2req_valid_o <= 1'b0;
			issue_strand_q <= '0;
			rsp_q <= '0;
		end
		else
		begin
			if (fill)
				line_valid_q[rsp_set] <= 1'b1;
			if (miss)
			begin
				wait_q[req_i.strand] <= 1'b1;
				sent_q[req_i.strand] <= 1'b0;
			end
			if (port_free)
			begin
				l2req_valid_o <= issue_cand != '0;
				if (issue_cand != '0)
				begin
					issue_strand_q <= issue_strand;
					sent_q[issue_strand] <= 1'b1;
				end
			end

			rsp_q.valid <= 1'b0;
			if (load && hit)
				rsp_q <= '{valid: 1'b1, strand: req_i.strand,
					data: merge_bytes(line_q[req_set][req_off], fwd_data_i, fwd_mask_i)};
			else if (done_q != '0)
			begin
				rsp_q <= '{valid: 1'b1, strand: done_strand, data: wait_data_q[done_strand]};
				wait_q[done_strand] <= 1'b0;
				done_q[done_strand] <= 1'b0;
			end
			else if (answer_fill)
			begin
				rsp_q <= '{valid: 1'b1, strand: fill_strand, data: fill_word};
				wait_q[fill_strand] <= 1'b0;
			end
			if (fill && !answer_fill)
				done_q[fill_strand] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_q[rsp_set] <= rsp_tag;
			line_q[rsp_set] <= l2rsp_i.data;
			wait_data_q[fill_strand] <= fill_word;
		end
		else if (ack && line_valid_q[rsp_set] && tag_q[rsp_set] == rsp_tag)
			line_q[rsp_set] <= l2rsp_i.data;	// Write-through update, no allocate
		if (miss)
		begin
			wait_addr_q[req_i.strand] <= req_i.addr;
			wait_data_q[req_i.strand] <= fwd_data_i;
			wait_mask_q[req_i.strand] <= fwd_mask_i;
		end
	end

endmodule

// ==== logic/l2_msg_pkg.sv ====
/* Message types of the shared L2 request and response channels.
   Used by the cache, the store buffer, the arbiter and the core top */
`include "core_settings.svh"

package l2_msg_pkg;

	typedef enum logic {
		L2_LOAD,	// Read a whole line
		L2_STORE	// Masked byte write into one line
	} l2_op_t;

	// Responses carry the unit back so each block claims its own
	typedef enum logic {
		UNIT_DCACHE,
		UNIT_STBUF
	} l2_unit_t;

	typedef logic [`LINE_WORDS-1:0][31:0] line_data_t;
	typedef logic [`LINE_WORDS-1:0][3:0]  line_mask_t;	// Byte enables per word

	typedef struct packed {
		logic [`CORE_BITS-1:0]      core;
		l2_unit_t                   unit;
		logic [`STRAND_BITS-1:0]    strand;
		l2_op_t                     op;
		logic [`LINE_ADDR_BITS-1:0] address;
		line_data_t                 data;
		line_mask_t                 mask;
	} l2_req_t;

	typedef struct packed {
		logic                       valid;
		logic [`CORE_BITS-1:0]      core;
		l2_unit_t                   unit;
		logic [`STRAND_BITS-1:0]    strand;
		l2_op_t                     op;
		logic [`LINE_ADDR_BITS-1:0] address;
		line_data_t                 data;	// Whole line after the write on a store
	} l2_rsp_t;

endpackage

// ==== logic/l2req_arbiter.sv ====
/* Round-robin arbiter between the data cache and the store buffer for the
   single L2 request port. Grant is combinational and locked while stalled */
`timescale 1ns/1ps

module l2req_arbiter (
	input  logic                clk,
	input  logic                reset,
	input  l2_msg_pkg::l2_req_t dcache_req_i,
	input  logic                dcache_valid_i,
	output logic                dcache_ready_o,
	input  l2_msg_pkg::l2_req_t stbuf_req_i,
	input  logic                stbuf_valid_i,
	output logic                stbuf_ready_o,
	output l2_msg_pkg::l2_req_t l2req_o,
	output logic                l2req_valid_o,
	input  logic                l2req_ready_i
);
	logic prio_stbuf_q;	// Store buffer wins a tie when set
	logic hold_q;	// Last cycle stalled, keep the same source
	logic hold_stbuf_q;
	logic pick_stbuf;

	assign pick_stbuf = hold_q ? hold_stbuf_q
		: stbuf_valid_i && (prio_stbuf_q || !dcache_valid_i);

	assign l2req_o = pick_stbuf ? stbuf_req_i : dcache_req_i;
	assign l2req_valid_o = dcache_valid_i || stbuf_valid_i;
	assign dcache_ready_o = l2req_ready_i && !pick_stbuf;
	assign stbuf_ready_o = l2req_ready_i && pick_stbuf;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prio_stbuf_q <= 1'b0;
			hold_q <= 1'b0;
			hold_stbuf_q <= 1'b0;
		end
		else
		begin
			hold_q <= l2req_valid_o && !l2req_ready_i;
			hold_stbuf_q <= pick_stbuf;
			if (l2req_valid_o && l2req_ready_i)
				prio_stbuf_q <= !pick_stbuf;	// Other source goes first next time
		end
	end

endmodule

// ==== logic/store_buffer.sv ====
/* Store buffer with one pending store per strand. Stores go to L2 oldest first,
   loads of the same strand see them by forwarding until the ack arrives */
`timescale 1ns/1ps
`include "core_settings.svh"

module store_buffer (
	input  logic                     clk,
	input  logic                     reset,
	input  core_mem_pkg::mem_req_t   req_i,
	output logic [31:0]              fwd_data_o,
	output logic [3:0]               fwd_mask_o,
	output logic [`STRAND_COUNT-1:0] rollback_o,
	output logic [`STRAND_COUNT-1:0] resume_o,
	output l2_msg_pkg::l2_req_t      l2req_o,
	output logic                     l2req_valid_o,
	input  logic                     l2req_ready_i,
	input  l2_msg_pkg::l2_rsp_t      l2rsp_i
);
	import core_mem_pkg::*;
	import l2_msg_pkg::*;

	localparam int STRANDS = `STRAND_COUNT;

	logic [STRANDS-1:0]         valid_q;
	logic [STRANDS-1:0]         sent_q;
	logic [`WORD_ADDR_BITS-1:0] addr_q [STRANDS];
	logic [31:0]                data_q [STRANDS];
	logic [3:0]                 mask_q [STRANDS];

	// Entered stores in arrival order, oldest at the head
	logic [`STRAND_BITS-1:0] order_q [STRANDS];
	logic [`STRAND_BITS-1:0] head_q;
	logic [`STRAND_BITS-1:0] tail_q;
	logic [`STRAND_BITS:0]   count_q;
	logic [`STRAND_BITS-1:0] issue_strand_q;

	logic                    store;
	logic                    enter;
	logic                    ack;
	logic                    port_free;
	logic                    pop;
	logic [`STRAND_BITS-1:0] req_strand;
	logic [`STRAND_BITS-1:0] ack_strand;

	assign req_strand = req_i.strand;
	assign store = req_i.valid && req_i.op == MEM_STORE;
	assign enter = store && !valid_q[req_strand];	// Busy slot means rollback
	assign ack_strand = l2rsp_i.strand;
	assign ack = l2rsp_i.valid && l2rsp_i.unit == UNIT_STBUF
		&& valid_q[ack_strand] && sent_q[ack_strand];
	assign port_free = !l2req_valid_o || l2req_ready_i;
	assign pop = port_free && count_q != '0;

	// Forward only to a load of the same strand and word
	assign fwd_data_o = data_q[req_strand];
	assign fwd_mask_o = (req_i.valid && req_i.op == MEM_LOAD && valid_q[req_strand]
		&& addr_q[req_strand] == req_i.addr) ? mask_q[req_strand] : 4'h0;

	always_comb
	begin
		l2req_o = '0;
		l2req_o.unit = UNIT_STBUF;
		l2req_o.strand = issue_strand_q;
		l2req_o.op = L2_STORE;
		l2req_o.address = addr_q[issue_strand_q][`WORD_ADDR_BITS-1:`OFFSET_BITS];
		// Place the word in its lane of the line
		l2req_o.data[addr_q[issue_strand_q][`OFFSET_BITS-1:0]] = data_q[issue_strand_q];
		l2req_o.mask[addr_q[issue_strand_q][`OFFSET_BITS-1:0]] = mask_q[issue_strand_q];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			sent_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			issue_strand_q <= '0;
			l2req_valid_o <= 1'b0;
			rollback_o <= '0;
			resume_o <= '0;
		end
		else
		begin
			rollback_o <= '0;
			resume_o <= '0;
			if (store && valid_q[req_strand])
				rollback_o[req_strand] <= 1'b1;
			if (enter)
			begin
				valid_q[req_strand] <= 1'b1;
				sent_q[req_strand] <= 1'b0;
				tail_q <= tail_q + 1'b1;
			end
			if (ack)
			begin
				valid_q[ack_strand] <= 1'b0;	// Slot free again
				sent_q[ack_strand] <= 1'b0;
				resume_o[ack_strand] <= 1'b1;
			end
			if (port_free)
			begin
				l2req_valid_o <= pop;
				if (pop)
				begin
					issue_strand_q <= order_q[head_q];
					sent_q[order_q[head_q]] <= 1'b1;
					head_q <= head_q + 1'b1;
				end
			end
			count_q <= count_q + enter - pop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enter)
		begin
			order_q[tail_q] <= req_strand;
			addr_q[req_strand] <= req_i.addr;
			data_q[req_strand] <= req_i.data;
			mask_q[req_strand] <= req_i.mask;
		end
	end

endmodule

// ==== tb.f ====
+incdir+logic
logic/l2_msg_pkg.sv
logic/core_mem_pkg.sv
logic/l1_data_cache.sv
logic/store_buffer.sv
logic/l2req_arbiter.sv
logic/core_mem.sv
tests/core_mem_checker.sv
tests/core_mem_tb.sv

// ==== tests/core_mem_checker.sv ====
/* Scoreboard for the core memory unit. Watches the DUT ports, keeps a reference
   memory per strand and checks load data, rollback, resume and the core ID */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_mem_checker #(
	parameter int CORE_ID = 0
) (
	input  logic                     clk,
	input  logic                     reset,
	input  core_mem_pkg::mem_req_t   req_i,
	input  core_mem_pkg::mem_rsp_t   rsp_i,
	input  logic [`STRAND_COUNT-1:0] rollback_i,
	input  logic [`STRAND_COUNT-1:0] resume_i,
	input  l2_msg_pkg::l2_req_t      l2req_i,
	input  logic                     l2req_valid_i,
	output int                       error_count_o
);
	import core_mem_pkg::*;

	localparam int STRANDS = `STRAND_COUNT;

	logic [31:0]        model [STRANDS][64];	// 64-word region of each strand
	logic [31:0]        expect_q [STRANDS];
	logic [STRANDS-1:0] load_wait;
	logic [STRANDS-1:0] store_busy;	// Entered and not resumed yet
	logic [STRANDS-1:0] store_new;	// Store sampled at the last edge
	logic [STRANDS-1:0] roll_expect;

	// Memory starts with a word derived from the full word address
	function automatic logic [31:0] start_word(input logic [29:0] addr);
		return ({2'b00, addr} * 32'h9E37_79B1) ^ {addr, 2'b10};
	endfunction

	initial
	begin
		error_count_o = 0;
		for (int s = 0; s < STRANDS; s++)
			for (int i = 0; i < 64; i++)
				model[s][i] = start_word(30'({1'b1, 2'(s), 6'(i)}));
	end

	always @(posedge clk)
	begin : check
		int s;
		if (reset)
		begin
			load_wait = '0;
			store_busy = '0;
			store_new = '0;
		end
		else
		begin
			if (rsp_i.valid)
			begin
				if (!load_wait[rsp_i.strand])
				begin
					$display("Load response for strand %0d with no load in flight at %0t",
						rsp_i.strand, $time);
					error_count_o++;
				end
				else if (rsp_i.data !== expect_q[rsp_i.strand])
				begin
					$display("[ERROR] %0t: strand %0d load returned %08h, expected %08h",
						$time, rsp_i.strand, rsp_i.data, expect_q[rsp_i.strand]);
					error_count_o++;
				end
				load_wait[rsp_i.strand] = 1'b0;
			end
			for (int i = 0; i < STRANDS; i++)
			begin
				if (resume_i[i] && !store_busy[i])
				begin
					$display("Resume for strand %0d with no store in flight at %0t", i, $time);
					error_count_o++;
				end
				if (resume_i[i])
					store_busy[i] = 1'b0;
				if (rollback_i[i] !== (store_new[i] && roll_expect[i]))
				begin
					$display("[ERROR] %0t: strand %0d rollback is %b, expected %b",
						$time, i, rollback_i[i], store_new[i] && roll_expect[i]);
					error_count_o++;
				end
			end
			store_new = '0;
			if (l2req_valid_i && l2req_i.core != CORE_ID)
			begin
				$display("[ERROR] %0t: L2 request carries core %0d, expected %0d",
					$time, l2req_i.core, CORE_ID);
				error_count_o++;
			end
			if (req_i.valid)
			begin
				s = req_i.strand;
				if (req_i.op == MEM_LOAD)
				begin
					expect_q[s] = model[s][req_i.addr[5:0]];	// Sees entered stores
					load_wait[s] = 1'b1;
				end
				else
				begin
					store_new[s] = 1'b1;
					roll_expect[s] = store_busy[s];	// Busy slot rolls back
					if (!store_busy[s])
					begin
						for (int b = 0; b < 4; b++)
							if (req_i.mask[b])
								model[s][req_i.addr[5:0]][b*8 +: 8] = req_i.data[b*8 +: 8];
						store_busy[s] = 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== tests/core_mem_tb.sv ====
/* Testbench for the core memory unit. Stands in for the pipeline and the L2,
   runs directed and random tests and prints a summary */
`timescale 1ns/1ps
`include "core_settings.svh"

module core_mem_tb;
	import core_mem_pkg::*;
	import l2_msg_pkg::*;

	localparam int CORE_ID = 1;
	localparam int ADDR_BITS = `WORD_ADDR_BITS;
	localparam int DIRECTED_REQS = 11;
	localparam int RANDOM_REQS = 240;
	localparam int CYCLE_LIMIT = 40 * (DIRECTED_REQS + RANDOM_REQS);

	logic                     clk;
	logic                     reset;
	mem_req_t                 req;
	mem_rsp_t                 rsp;
	logic [`STRAND_COUNT-1:0] rollback;
	logic [`STRAND_COUNT-1:0] resume;
	l2_req_t                  l2req;
	logic                     l2req_valid;
	logic                     l2req_ready;
	l2_rsp_t                  l2rsp;

	logic [31:0] mem [512];	// L2 backing store of words
	l2_rsp_t     rsp_queue [$];
	int          due_queue [$];
	int          last_due;
	int          issued [`STRAND_COUNT];
	int          finished [`STRAND_COUNT];
	int          cycle;
	int          noise_pct;	// Chance of a foreign response in an idle cycle
	int          tb_errors;
	int          checker_errors;
	int          errors_before;
	int          tests_run;
	int          tests_failed;

	core_mem #(.CORE_ID(CORE_ID)) core_mem_i (
		.clk           (clk),
		.reset         (reset),
		.req_i         (req),
		.rsp_o         (rsp),
		.rollback_o    (rollback),
		.resume_o      (resume),
		.l2req_o       (l2req),
		.l2req_valid_o (l2req_valid),
		.l2req_ready_i (l2req_ready),
		.l2rsp_i       (l2rsp)
	);

	core_mem_checker #(.CORE_ID(CORE_ID)) core_mem_checker_i (
		.clk           (clk),
		.reset         (reset),
		.req_i         (req),
		.rsp_i         (rsp),
		.rollback_i    (rollback),
		.resume_i      (resume),
		.l2req_i       (l2req),
		.l2req_valid_i (l2req_valid),
		.error_count_o (checker_errors)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	function automatic logic [31:0] start_word(input logic [29:0] addr);
		return ({2'b00, addr} * 32'h9E37_79B1) ^ {addr, 2'b10};
	endfunction

	// t selects one of two tags inside a strand's region
	function automatic logic [ADDR_BITS-1:0] region_addr(input int s, input int t,
		input int set, input int off);
		return ADDR_BITS'({1'b1, 2'(s), 1'(t), 3'(set), 2'(off)});
	endfunction

	function automatic logic strand_busy(input int s);
		return issued[s] != finished[s];
	endfunction

	// Stores land in memory when the L2 accepts them
	always @(posedge clk)
	begin : l2_accept
		l2_rsp_t r;
		int base;
		int due;
		if (!reset && l2req_valid && l2req_ready)
		begin
			base = int'(l2req.address) * 4;
			for (int w = 0; w < `LINE_WORDS; w++)
			begin
				if (l2req.op == L2_STORE)
					for (int b = 0; b < 4; b++)
						if (l2req.mask[w][b])
							mem[base + w][b*8 +: 8] = l2req.data[w][b*8 +: 8];
				r.data[w] = mem[base + w];
			end
			r.valid = 1'b1;
			r.core = l2req.core;
			r.unit = l2req.unit;
			r.strand = l2req.strand;
			r.op = l2req.op;
			r.address = l2req.address;
			due = cycle + 2 + $urandom_range(4);
			if (due <= last_due)
				due = last_due + 1;	// Keep answers in order
			last_due = due;
			rsp_queue.push_back(r);
			due_queue.push_back(due);
		end
	end

	// Cycle count, timeout, ready and response driving
	always @(negedge clk)
	begin : l2_drive
		l2_rsp_t noise;
		cycle++;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, some request never finished", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
		else
		begin
			l2req_ready = !reset && $urandom_range(99) < 70;
			l2rsp = '0;
			if (due_queue.size() > 0 && due_queue[0] <= cycle)
			begin
				l2rsp = rsp_queue.pop_front();
				void'(due_queue.pop_front());
			end
			else if (!reset && $urandom_range(99) < noise_pct)
			begin
				noise.valid = 1'b1;
				noise.core = 2'((CORE_ID + 1 + $urandom_range(2)) % `CORE_COUNT);
				noise.unit = l2_unit_t'($urandom_range(1));
				noise.strand = 2'($urandom_range(3));
				noise.op = l2_op_t'($urandom_range(1));
				noise.address = 26'(7'h40 | $urandom_range(63));	// Lines the strands use
				noise.data = {$urandom, $urandom, $urandom, $urandom};
				l2rsp = noise;
			end
		end
	end

	// A request ends with its load answer, rollback or resume
	always @(posedge clk)
		if (!reset)
			for (int s = 0; s < `STRAND_COUNT; s++)
				finished[s] += (rsp.valid && rsp.strand == s) + rollback[s] + resume[s];

	task automatic issue(input int s, input mem_op_t op, input logic [ADDR_BITS-1:0] addr,
		input logic [31:0] data, input logic [3:0] mask);
		req.valid = 1'b1;
		req.strand = 2'(s);
		req.op = op;
		req.addr = addr;
		req.data = data;
		req.mask = mask;
		issued[s]++;
		@(negedge clk);
		req.valid = 1'b0;
	endtask

	task automatic wait_idle();
		for (int s = 0; s < `STRAND_COUNT; s++)
			while (strand_busy(s))
				@(negedge clk);
	endtask

	task automatic end_test(input string name);
		int now_errors;
		now_errors = tb_errors + checker_errors;
		tests_run++;
		if (now_errors == errors_before)
			$display("Test %0d %s: ok", tests_run, name);
		else
		begin
			$display("Test %0d %s: failed with %0d errors", tests_run, name,
				now_errors - errors_before);
			tests_failed++;
		end
		errors_before = now_errors;
	endtask

	initial
	begin : main
		int n;
		int s;
		void'($urandom(48));
		req = '0;
		l2req_ready = 1'b0;
		l2rsp = '0;
		reset = 1'b1;
		noise_pct = 10;
		for (int a = 0; a < 512; a++)
			mem[a] = start_word(30'(a));
		for (int i = 0; i < `STRAND_COUNT; i++)
		begin
			issued[i] = 0;
			finished[i] = 0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		repeat (8)
		begin
			@(negedge clk);
			if (rsp.valid || rollback != '0 || resume != '0 || l2req_valid)
			begin
				$display("Outputs active with no request at %0t", $time);
				tb_errors++;
			end
		end
		issue(0, MEM_LOAD, region_addr(0, 0, 3, 1), '0, '0);	// Cold miss
		wait_idle();
		issue(0, MEM_LOAD, region_addr(0, 0, 3, 1), '0, '0);
		if (!(rsp.valid && rsp.strand == 0))
		begin
			$display("Load hit was not answered in the next cycle at %0t", $time);
			tb_errors++;
		end
		wait_idle();
		end_test("reset, miss and hit");

		issue(1, MEM_STORE, region_addr(1, 1, 5, 2), 32'hA5C3_1E77, 4'b0101);
		issue(1, MEM_LOAD, region_addr(1, 1, 5, 2), '0, '0);	// Store still pending
		wait_idle();
		end_test("load forwarding");

		issue(2, MEM_STORE, region_addr(2, 0, 6, 3), 32'h1234_5678, 4'hF);
		issue(2, MEM_STORE, region_addr(2, 0, 6, 3), 32'hDEAD_BEEF, 4'hF);
		if (!rollback[2])
		begin
			$display("Second store was not rolled back at %0t", $time);
			tb_errors++;
		end
		wait_idle();
		issue(2, MEM_LOAD, region_addr(2, 0, 6, 3), '0, '0);
		wait_idle();
		end_test("store rollback");

		n = 0;
		while (n < RANDOM_REQS)
		begin
			s = $urandom_range(3);
			if (!strand_busy(s) && $urandom_range(99) < 60)
			begin
				issue(s, $urandom_range(1) ? MEM_STORE : MEM_LOAD,
					region_addr(s, $urandom_range(1), $urandom_range(7), $urandom_range(3)),
					$urandom, 4'($urandom_range(15, 1)));
				n++;
			end
			else
				@(negedge clk);
		end
		wait_idle();
		end_test("random traffic");

		noise_pct = 70;
		for (int i = 0; i < `STRAND_COUNT; i++)
			issue(i, MEM_LOAD, region_addr(i, 0, 3, 1), '0, '0);
		repeat (20) @(negedge clk);	// Mostly foreign responses
		wait_idle();
		noise_pct = 10;
		end_test("foreign responses");

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			tb_errors + checker_errors);
		if (tests_failed == 0 && tb_errors + checker_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
